// File: test/controlUnitGolden.txt
# F <fetch step 0-3 word> <fetch step 4 word> <decode word>
# I <name> <opcode> <funct> <execute length> <execute word 0> <word 1> <word 2> <word 3>
# R <number of random illegal opcode/funct pairs>
# Words are 16-bit hex control words, unused execute words are 0000
F e090 38b0 0000
# Kept instructions
I ADD    00 20 2 04c0 0104 0000 0000
I ADDI   08 15 2 04e0 0100 0000 0000
I MFHI   00 10 1 0105 0000 0000 0000
I MFLO   00 12 1 0106 0000 0000 0000
I LB     20 3f 4 04e0 2008 2208 0103
# Dropped instructions decode as illegal and return to fetch
I SUB    00 22 0 0000 0000 0000 0000
I AND    00 24 0 0000 0000 0000 0000
I SLT    00 2a 0 0000 0000 0000 0000
I SLL    00 00 0 0000 0000 0000 0000
I DIV    00 1a 0 0000 0000 0000 0000
I MULT   00 18 0 0000 0000 0000 0000
I JR     00 08 0 0000 0000 0000 0000
I BEQ    04 00 0 0000 0000 0000 0000
I J      02 00 0 0000 0000 0000 0000
I SW     2b 00 0 0000 0000 0000 0000
I LUI    0f 00 0 0000 0000 0000 0000
# Random illegal pairs
R 12
# Kept instructions again after the illegal run
I ADD    00 20 2 04c0 0104 0000 0000
I LB     20 00 4 04e0 2008 2208 0103
I MFLO   00 12 1 0106 0000 0000 0000
I ADDI   08 3f 2 04e0 0100 0000 0000
I MFHI   00 10 1 0105 0000 0000 0000
R 4
I LB     20 2a 4 04e0 2008 2208 0103
I ADD    00 20 2 04c0 0104 0000 0000

// File: controlUnit.f
verilog/isaPkg.sv
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/controlWordRom.sv
verilog/controlUnit.sv
test/controlUnitTb.sv

// File: Bender.yml
package:
  name: controlUnit

sources:
  - verilog/isaPkg.sv
  - verilog/controlPkg.sv
  - verilog/instrDecoder.sv
  - verilog/stepSequencer.sv
  - verilog/controlWordRom.sv
  - verilog/controlUnit.sv
  - target: test
    files:
      - test/controlUnitTb.sv

// File: test/controlUnitTb.sv
`default_nettype none

module controlUnitTb;

    import isaPkg::*;
    import controlPkg::*;

    localparam int wordW = $bits(controlWord_t);
    localparam int fetchTimeout = 20;
    localparam int junkTries = 32;
    // Fetch length of every instruction, steps 0 to 4
    localparam int fetchCycles = 5;

    logic clk;
    logic reset;
    logic [opcodeW-1:0] opcode;
    logic [functW-1:0] funct;
    controlWord_t ctrl;

    integer seed;
    int cycleCount;
    int errorCount;
    int testsRun;
    int testsFailed;
    int releaseCycle;
    int prevStart;
    int expSpacing;
    bit havePrev;
    bit aborted;

    // Fetch and decode words from the golden file
    logic [wordW-1:0] fetchWord;
    logic [wordW-1:0] lastFetchWord;
    logic [wordW-1:0] decodeWord;

    controlUnit i_dut (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .ctrl(ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // All sampling and driving happens right after a falling edge
    task nextCycle;
        @(negedge clk);
        cycleCount++;
    endtask

    task automatic checkWord(input string sigName, input logic [wordW-1:0] got,
                             input logic [wordW-1:0] exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s = %h, expected %h", $time, sigName, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string sigName, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error at time %0t: %s = %0d, expected %0d", $time, sigName, got, exp);
            errorCount++;
        end
    endtask

    task automatic waitForFetch(output bit found);
        int waited;
        waited = 0;
        found = ctrl.enables.irWrite;
        while (!found && waited < fetchTimeout) begin
            nextCycle();
            waited++;
            found = ctrl.enables.irWrite;
        end
        if (!found) begin
            $display("Timeout at time %0t: irWrite did not rise within %0d cycles",
                     $time, fetchTimeout);
            errorCount++;
        end
    endtask

    // Opcode/funct pairs of the kept instructions
    function automatic bit isKept(input logic [opcodeW-1:0] op, input logic [functW-1:0] fn);
        if (op == opAddi || op == opLb) begin
            return 1'b1;
        end
        return op == opRType && (fn == fnAdd || fn == fnMfhi || fn == fnMflo);
    endfunction

    // One instruction from fetch step 0 up to the next fetch step 0
    task automatic runInstr(input string name, input logic [opcodeW-1:0] op,
                            input logic [functW-1:0] fn, input int len,
                            input logic [wordW-1:0] words [4]);
        bit found;
        int errBefore;
        logic [31:0] junk;
        errBefore = errorCount;
        waitForFetch(found);
        if (!found) begin
            aborted = 1'b1;
            return;
        end
        if (havePrev) begin
            checkCount("irWrite start spacing", cycleCount - prevStart, expSpacing);
        end else begin
            checkCount("cycles from reset release to fetch", cycleCount - releaseCycle, 1);
        end
        havePrev = 1'b1;
        prevStart = cycleCount;
        expSpacing = fetchCycles + 1 + len;
        opcode = op;
        funct = fn;
        for (int i = 0; i < fetchCycles - 1; i++) begin
            checkWord($sformatf("ctrl (%s fetch step %0d)", name, i), ctrl, fetchWord);
            nextCycle();
        end
        checkWord($sformatf("ctrl (%s fetch step 4)", name), ctrl, lastFetchWord);
        nextCycle();
        checkWord($sformatf("ctrl (%s decode)", name), ctrl, decodeWord);
        nextCycle();
        // DUT ignores the inputs after decode
        junk = $random(seed);
        opcode = junk[5:0];
        funct = junk[11:6];
        for (int i = 0; i < len; i++) begin
            checkWord($sformatf("ctrl (%s execute step %0d)", name, i), ctrl, words[i]);
            nextCycle();
        end
        checkWord($sformatf("ctrl (%s return to fetch)", name), ctrl, fetchWord);
        testsRun++;
        if (errorCount == errBefore) begin
            $display("Test %-8s op=%h fn=%h len=%0d: pass", name, op, fn, len);
        end else begin
            testsFailed++;
            $display("Test %-8s op=%h fn=%h len=%0d: FAIL, %0d mismatches",
                     name, op, fn, len, errorCount - errBefore);
        end
    endtask

    task automatic runRandomIllegal(input int count);
        logic [wordW-1:0] noWords [4];
        logic [31:0] r;
        logic [opcodeW-1:0] op;
        logic [functW-1:0] fn;
        int tries;
        noWords = '{default: '0};
        for (int n = 0; n < count && !aborted; n++) begin
            tries = 0;
            op = opAddi;
            fn = '0;
            while (isKept(op, fn) && tries < junkTries) begin
                r = $random(seed);
                // Half of them R-type to cover illegal funct codes
                op = r[12] ? opRType : r[5:0];
                fn = r[11:6];
                tries++;
            end
            if (isKept(op, fn)) begin
                $display("Random generator found no illegal pair for test %0d", n);
                errorCount++;
            end else begin
                runInstr($sformatf("RND%0d", n), op, fn, 0, noWords);
            end
        end
    endtask

    initial begin
        int fd;
        int n;
        int len;
        int errBefore;
        bit done;
        logic [8*16-1:0] tag;
        logic [8*16-1:0] nameTok;
        logic [8*128-1:0] lineBuf;
        logic [opcodeW-1:0] op;
        logic [functW-1:0] fn;
        logic [wordW-1:0] words [4];

        reset = 1'b1;
        opcode = '0;
        funct = '0;
        seed = 40;
        cycleCount = 0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        havePrev = 1'b0;
        aborted = 1'b0;
        fetchWord = '0;
        lastFetchWord = '0;
        decodeWord = '0;

        // Idle word over both reset edges
        errBefore = errorCount;
        nextCycle();
        checkWord("ctrl (in reset)", ctrl, '0);
        nextCycle();
        checkWord("ctrl (in reset)", ctrl, '0);
        reset = 1'b0;
        releaseCycle = cycleCount;
        testsRun++;
        if (errorCount == errBefore) begin
            $display("Test RESET: pass");
        end else begin
            testsFailed++;
            $display("Test RESET: FAIL");
        end
        nextCycle();

        fd = $fopen("test/controlUnitGolden.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/controlUnitGolden.txt");
            aborted = 1'b1;
        end
        done = (fd == 0);
        while (!done && !aborted) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                n = $fgets(lineBuf, fd);
            end else if (tag == "F") begin
                n = $fscanf(fd, "%h %h %h", fetchWord, lastFetchWord, decodeWord);
                if (n != 3) begin
                    $display("Malformed fetch record in golden file");
                    errorCount++;
                    done = 1'b1;
                end
            end else if (tag == "I") begin
                n = $fscanf(fd, "%s %h %h %d %h %h %h %h", nameTok, op, fn, len,
                            words[0], words[1], words[2], words[3]);
                if (n != 8) begin
                    $display("Malformed instruction record in golden file");
                    errorCount++;
                    done = 1'b1;
                end else begin
                    runInstr($sformatf("%0s", nameTok), op, fn, len, words);
                end
            end else if (tag == "R") begin
                n = $fscanf(fd, "%d", len);
                if (n != 1) begin
                    $display("Malformed random record in golden file");
                    errorCount++;
                    done = 1'b1;
                end else begin
                    runRandomIllegal(len);
                end
            end else begin
                $display("Unknown record in golden file: %0s", tag);
                errorCount++;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0 && !aborted) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/controlUnit.sv
`default_nettype none

module controlUnit (
    input logic clk,
    input logic reset,
    input logic [isaPkg::opcodeW-1:0] opcode,
    input logic [isaPkg::functW-1:0] funct,
    output controlPkg::controlWord_t ctrl
);

    import isaPkg::*;
    import controlPkg::*;

    instrClass_t instrClass;
    instrClass_t execClass;
    phase_t phase;
    logic [stepW-1:0] step;
    logic lastStep;

    instrDecoder i_decoder (
        .opcode(opcode),
        .funct(funct),
        .instrClass(instrClass)
    );

    // Class is sampled here only in the decode cycle
    stepSequencer i_sequencer (
        .clk(clk),
        .reset(reset),
        .instrClass(instrClass),
        .lastStep(lastStep),
        .phase(phase),
        .step(step),
        .execClass(execClass)
    );

    controlWordRom i_wordRom (
        .phase(phase),
        .execClass(execClass),
        .step(step),
        .ctrl(ctrl),
        .lastStep(lastStep)
    );

endmodule

`default_nettype wire

// File: verilog/controlWordRom.sv
`default_nettype none

module controlWordRom (
    input controlPkg::phase_t phase,
    input isaPkg::instrClass_t execClass,
    input logic [isaPkg::stepW-1:0] step,
    output controlPkg::controlWord_t ctrl,
    output logic lastStep
);

    import isaPkg::*;
    import controlPkg::*;

    localparam logic [stepW-1:0] lastFetch = stepW'(fetchSteps - 1);

    always_comb begin
        ctrl = ctrlIdle;
        lastStep = 1'b0;
        case (phase)
            phFetch: begin
                ctrl.enables.memRead = 1'b1;
                ctrl.selects.aluOp = aluAdd;
                ctrl.selects.aluSrcA = srcAPc;
                ctrl.selects.iorD = addrPc;
                if (step < lastFetch) begin
                    // PC + 4, instruction latched into IR
                    ctrl.enables.pcWrite = 1'b1;
                    ctrl.enables.irWrite = 1'b1;
                    ctrl.selects.aluSrcB = srcBFour;
                end else begin
                    // Load A and B, ALU precomputes the branch target
                    ctrl.enables.regAWrite = 1'b1;
                    ctrl.enables.regBWrite = 1'b1;
                    ctrl.selects.aluSrcB = srcBBranchOff;
                end
            end
            phExecute: begin
                case (execClass)
                    clsAdd, clsAddi: begin
                        // Two cycles: ALU into ALUOut, then write back
                        lastStep = (step == stepW'(1));
                        if (step == stepW'(0)) begin
                            ctrl.enables.aluOutWrite = 1'b1;
                            ctrl.selects.aluOp = aluAdd;
                            ctrl.selects.aluSrcA = srcARegA;
                            ctrl.selects.aluSrcB =
                                (execClass == clsAddi) ? srcBImm : srcBRegB;
                        end else begin
                            ctrl.enables.regWrite = 1'b1;
                            ctrl.selects.regDst =
                                (execClass == clsAddi) ? dstRt : dstRd;
                            ctrl.selects.memToReg = wbAluOut;
                        end
                    end
                    clsMfhi, clsMflo: begin
                        // Single write-back cycle from Hi or Lo
                        lastStep = 1'b1;
                        ctrl.enables.regWrite = 1'b1;
                        ctrl.selects.regDst = dstRd;
                        ctrl.selects.memToReg =
                            (execClass == clsMfhi) ? wbHi : wbLo;
                    end
                    clsLb: begin
                        lastStep = (step == stepW'(3));
                        case (step)
                            stepW'(0): begin
                                // Effective address rs + imm
                                ctrl.enables.aluOutWrite = 1'b1;
                                ctrl.selects.aluOp = aluAdd;
                                ctrl.selects.aluSrcA = srcARegA;
                                ctrl.selects.aluSrcB = srcBImm;
                            end
                            stepW'(1): begin
                                ctrl.enables.memRead = 1'b1;
                                ctrl.selects.iorD = addrAluOut;
                            end
                            stepW'(2): begin
                                // Memory data valid, capture into MDR
                                ctrl.enables.memRead = 1'b1;
                                ctrl.enables.mdrWrite = 1'b1;
                                ctrl.selects.iorD = addrAluOut;
                            end
                            default: begin
                                ctrl.enables.regWrite = 1'b1;
                                ctrl.selects.regDst = dstRt;
                                ctrl.selects.memToReg = wbMemByte;
                            end
                        endcase
                    end
                    default: begin
                        // Not reachable, the sequencer never executes clsIllegal
                        lastStep = 1'b1;
                    end
                endcase
            end
            default: begin
                // Reset and decode drive the idle word
                ctrl = ctrlIdle;
            end
        endcase
    end

    // Register file write and memory read share no cycle
    always_comb begin
        assert final (!(ctrl.enables.regWrite && ctrl.enables.memRead))
            else $error("regWrite and memRead active in the same cycle");
    end

    // PC only advances during fetch
    always_comb begin
        assert final (!ctrl.enables.pcWrite || phase == phFetch)
            else $error("pcWrite active outside fetch");
    end

endmodule

`default_nettype wire

// File: verilog/stepSequencer.sv
`default_nettype none

module stepSequencer (
    input logic clk,
    input logic reset,
    input isaPkg::instrClass_t instrClass,
    input logic lastStep,
    output controlPkg::phase_t phase,
    output logic [isaPkg::stepW-1:0] step,
    output isaPkg::instrClass_t execClass
);

    import isaPkg::*;
    import controlPkg::*;

    localparam logic [stepW-1:0] lastFetch = stepW'(fetchSteps - 1);

    // Phase register and step counter
    // step restarts from zero on every phase change
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phReset;
            step <= '0;
        end else begin
            case (phase)
                phReset: begin
                    phase <= phFetch;
                    step <= '0;
                end
                phFetch: begin
                    if (step == lastFetch) begin
                        phase <= phDecode;
                        step <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                phDecode: begin
                    // Illegal pairs skip execute entirely
                    if (instrClass == clsIllegal) begin
                        phase <= phFetch;
                    end else begin
                        phase <= phExecute;
                    end
                    step <= '0;
                end
                phExecute: begin
                    if (lastStep) begin
                        phase <= phFetch;
                        step <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    phase <= phReset;
                    step <= '0;
                end
            endcase
        end
    end

    // Class captured at decode so execute is independent of the opcode inputs
    always_ff @(posedge clk) begin
        if (phase == phDecode) begin
            execClass <= instrClass;
        end
    end

    // Fetch ends on step fetchSteps-1, the counter never gets past it
    assert property (@(posedge clk) disable iff (reset)
        phase == phFetch |-> step < fetchSteps)
        else $error("fetch step counter ran past the last fetch step");

    // Illegal class must have been diverted to fetch at decode
    assert property (@(posedge clk) disable iff (reset)
        phase == phExecute |-> execClass != clsIllegal)
        else $error("execute phase entered with an illegal class");

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input logic [isaPkg::opcodeW-1:0] opcode,
    input logic [isaPkg::functW-1:0] funct,
    output isaPkg::instrClass_t instrClass
);

    import isaPkg::*;

    always_comb begin
        case (opcode)
            opRType: begin
                // R-type, class comes from funct
                case (funct)
                    fnAdd: begin
                        instrClass = clsAdd;
                    end
                    fnMfhi: begin
                        instrClass = clsMfhi;
                    end
                    fnMflo: begin
                        instrClass = clsMflo;
                    end
                    default: begin
                        instrClass = clsIllegal;
                    end
                endcase
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opLb: begin
                instrClass = clsLb;
            end
            default: begin
                // Unsupported opcode goes back to fetch after decode
                instrClass = clsIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/controlPkg.sv
`default_nettype none

package controlPkg;

    // Top-level sequencing phase
    typedef enum logic [1:0] {
        phReset,
        phFetch,
        phDecode,
        phExecute
    } phase_t;

    // ALU operation
    typedef enum logic {
        aluNone,
        aluAdd
    } aluOp_t;

    // ALU operand A
    typedef enum logic {
        srcAPc,
        srcARegA
    } aluSrcA_t;

    // ALU operand B
    // Branch offset is the shifted sign-extended immediate
    typedef enum logic [1:0] {
        srcBRegB,
        srcBFour,
        srcBImm,
        srcBBranchOff
    } aluSrcB_t;

    // Memory address source
    typedef enum logic {
        addrPc,
        addrAluOut
    } iorD_t;

    // Register file write address
    typedef enum logic {
        dstRt,
        dstRd
    } regDst_t;

    // Register file write data
    typedef enum logic [1:0] {
        wbAluOut,
        wbHi,
        wbLo,
        wbMemByte
    } memToReg_t;

    // Write and read strobes to the datapath
    typedef struct packed {
        logic pcWrite;
        logic irWrite;
        logic memRead;
        logic regAWrite;
        logic regBWrite;
        logic aluOutWrite;
        logic mdrWrite;
        logic regWrite;
    } ctrlEnables_t;

    // Mux selects and ALU op
    typedef struct packed {
        aluOp_t aluOp;
        aluSrcA_t aluSrcA;
        aluSrcB_t aluSrcB;
        iorD_t iorD;
        regDst_t regDst;
        memToReg_t memToReg;
    } ctrlSelects_t;

    typedef struct packed {
        ctrlEnables_t enables;
        ctrlSelects_t selects;
    } controlWord_t;

    // All strobes off, every select at its first member
    localparam controlWord_t ctrlIdle = '0;

endpackage

`default_nettype wire

// File: verilog/isaPkg.sv
`default_nettype none

package isaPkg;

    // Instruction field widths
    localparam int unsigned opcodeW = 6;
    localparam int unsigned functW = 6;

    // Opcodes of the supported instructions
    // R-type shares opcode zero, the funct field tells them apart
    localparam logic [opcodeW-1:0] opRType = 6'h00;
    localparam logic [opcodeW-1:0] opAddi = 6'h08;
    localparam logic [opcodeW-1:0] opLb = 6'h20;

    // Funct codes under the R-type opcode
    localparam logic [functW-1:0] fnAdd = 6'h20;
    localparam logic [functW-1:0] fnMfhi = 6'h10;
    localparam logic [functW-1:0] fnMflo = 6'h12;

    // Decoded instruction class
    // Anything outside the supported set collapses to clsIllegal
    typedef enum logic [2:0] {
        clsAdd,
        clsAddi,
        clsMfhi,
        clsMflo,
        clsLb,
        clsIllegal
    } instrClass_t;

    // Step counter, wide enough for fetch and the longest execute
    localparam int unsigned stepW = 3;

    // Fetch takes steps 0 to fetchSteps-1
    localparam int unsigned fetchSteps = 5;

endpackage

`default_nettype wire
